// File: tetris.f
+incdir+hw
hw/boardPkg.sv
hw/piecePkg.sv
hw/boardRow.sv
hw/lineClearScore.sv
hw/pieceControl.sv
hw/tetrisTop.sv
bench/tetris_props.sv
bench/tetrisTb.sv

// File: Makefile
TOP = tetrisTb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f tetris.f

sim:
	verilator --binary --assert --top-module $(TOP) -f tetris.f -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -q "^Verification passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

// File: bench/tetrisTb.sv
`timescale 1ns/1ps
`include "tetris_consts.svh"

module tetrisTb;

    logic                      clk;
    logic                      rst;
    piecePkg::keyCode          key;
    piecePkg::pieceKind        pieceType;
    logic                      ready;
    boardPkg::gameScore        score;
    logic [`VISIBLE_CELLS-1:0] objects;
    logic                      gameOver;

    int                        lockCount;
    int                        clearCount;
    int                        pieces;
    logic [`VISIBLE_CELLS-1:0] frozen;

    tetrisTop u_dut (
        .clk       (clk),
        .rst       (rst),
        .key       (key),
        .pieceType (pieceType),
        .ready     (ready),
        .score     (score),
        .objects   (objects),
        .gameOver  (gameOver)
    );

    always #50 clk = ~clk;

    // ####################
    // Helpers
    // ####################

    task automatic failRun(string msg);
        $display("%s", msg);
        $display("Verification failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic checkBoard(string name, logic [`VISIBLE_CELLS-1:0] expected,
                              logic [`VISIBLE_CELLS-1:0] actual);
        assert (actual == expected) else begin
            failRun($sformatf("MISMATCH %s expected %0h actual %0h", name, expected, actual));
        end
    endtask

    task automatic checkNum(string name, int expected, int actual);
        assert (actual == expected) else begin
            failRun($sformatf("MISMATCH %s expected %0d actual %0d", name, expected, actual));
        end
    endtask

    // Columns firstCol..lastCol of one visible row
    function automatic logic [`VISIBLE_CELLS-1:0] cellsAt(int v, int firstCol, int lastCol);
        logic [`VISIBLE_CELLS-1:0] bits;
        bits = '0;
        for (int c = firstCol; c <= lastCol; c++) begin
            bits[v * `BOARD_COLS + c] = 1'b1;
        end
        return bits;
    endfunction

    task automatic applyReset();
        rst = 1'b1;
        key = piecePkg::keyIdle;
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
    endtask

    // Polls just after each rising edge
    task automatic waitReady(string what, bit stopOnOver);
        int n;
        n = 0;
        while (!(ready || (stopOnOver && gameOver))) begin
            @(posedge clk);
            #1;
            n++;
            if (n > 200) begin
                failRun($sformatf("timed out waiting for ready %s", what));
            end
        end
    endtask

    // Key held until one edge with ready high takes it
    task automatic sendKey(piecePkg::keyCode k);
        key = k;
        waitReady("while holding a key", 1'b0);
        @(posedge clk);
        #1;
        key = piecePkg::keyIdle;
    endtask

    task automatic dropToLock();
        int n;
        n = 0;
        do begin
            sendKey(piecePkg::keyDrop);
            n++;
            if (n > 30) begin
                failRun("piece did not lock after 30 drops");
            end
        end while (ready);
    endtask

    // Score follows locks and shift cycles, one cycle late
    always @(negedge clk) begin
        if (rst) begin
            lockCount = 0;
            clearCount = 0;
        end else begin
            checkNum("score tracking",
                     (lockCount * `LOCK_POINTS + clearCount * `LINE_POINTS) % 128,
                     int'(score));
            if (u_dut.lock) begin
                lockCount++;
            end
            if (u_dut.shiftEn != '0) begin
                clearCount++;
            end
        end
    end

    // ####################
    // Scenarios
    // ####################

    initial begin
        void'($urandom(32'hb91d6046));
        clk = 1'b0;
        rst = 1'b1;
        key = piecePkg::keyIdle;
        pieceType = piecePkg::kindI;
        applyReset();

        // Spawned piece sits in the hidden rows
        waitReady("after reset", 1'b0);
        checkBoard("reset objects", '0, objects);
        checkNum("reset score", 0, int'(score));
        checkNum("reset gameOver", 0, int'(gameOver));

        // I against the left wall, center column 2
        repeat (12) sendKey(piecePkg::keyLeft);
        repeat (2) sendKey(piecePkg::keyDrop);
        checkBoard("wall stop", cellsAt(0, 0, 3), objects);

        dropToLock();
        waitReady("after the first lock", 1'b0);
        checkBoard("first lock objects", cellsAt(19, 0, 3), objects);
        checkNum("first lock score", `LOCK_POINTS, int'(score));

        // Second piece must be an I again, centered on column 6
        sendKey(piecePkg::keyRight);
        repeat (2) sendKey(piecePkg::keyDrop);
        checkBoard("second piece", cellsAt(0, 4, 7) | cellsAt(19, 0, 3), objects);
        pieceType = piecePkg::kindO;
        dropToLock();
        waitReady("after the second lock", 1'b0);
        checkBoard("second lock objects", cellsAt(19, 0, 7), objects);

        // O at columns 8 and 9 completes the bottom row
        repeat (3) sendKey(piecePkg::keyRight);
        dropToLock();
        waitReady("after the line clear", 1'b0);
        checkNum("line clear score", 3 * `LOCK_POINTS + `LINE_POINTS, int'(score));
        checkBoard("line clear objects", cellsAt(19, 8, 9), objects);

        // Stack of O pieces in columns 5 and 6
        pieceType = piecePkg::kindO;
        applyReset();
        pieces = 0;
        waitReady("before the O stack", 1'b0);
        while (!gameOver) begin
            dropToLock();
            pieces++;
            if (pieces > 12) begin
                failRun("game over did not happen within 12 pieces");
            end
            waitReady("after an O lock", 1'b1);
        end
        checkNum("game over score", pieces * `LOCK_POINTS, int'(score));
        frozen = objects;
        repeat (20) begin
            @(posedge clk);
            #1;
            checkNum("game over ready", 0, int'(ready));
            checkBoard("game over objects", frozen, objects);
        end

        // Random play, restarted after each game over
        applyReset();
        for (int i = 0; i < 300; i++) begin
            waitReady("in random play", 1'b1);
            if (gameOver) begin
                applyReset();
                waitReady("after a restart", 1'b0);
            end
            pieceType = piecePkg::pieceKind'($urandom_range(7, 0));
            case ($urandom_range(3, 0))
                0: sendKey(piecePkg::keyLeft);
                1: sendKey(piecePkg::keyRight);
                default: sendKey(piecePkg::keyDrop);
            endcase
        end

        $display("Verification passed");
        $finish;
    end

endmodule

// File: bench/tetris_props.sv
`timescale 1ns/1ps
`include "tetris_consts.svh"

module tetrisProps (
    input logic               clk,
    input logic               rst,
    input logic               ready,
    input logic               gameOver,
    input boardPkg::gameScore score
);

    // Game over holds until reset
    overHolds: assert property (@(posedge clk) disable iff (rst)
        gameOver |=> gameOver)
        else $error("gameOver fell without a reset");

    noReadyInOver: assert property (@(posedge clk) disable iff (rst)
        !(ready && gameOver))
        else $error("ready was high during game over");

    // ####################
    // Score steps
    // ####################

    // No change, one lock, or one cleared row per cycle
    scoreStep: assert property (@(posedge clk) disable iff (rst)
        (score == $past(score)) ||
        (score == boardPkg::gameScore'($past(score) + `LOCK_POINTS)) ||
        (score == boardPkg::gameScore'($past(score) + `LINE_POINTS)))
        else $error("score changed by an unexpected step");

endmodule

bind tetrisTop tetrisProps u_props (
    .clk      (clk),
    .rst      (rst),
    .ready    (ready),
    .gameOver (gameOver),
    .score    (score)
);

// File: hw/tetrisTop.sv
`timescale 1ns/1ps
`include "tetris_consts.svh"

module tetrisTop (
    input  logic                     clk,
    input  logic                     rst,
    input  piecePkg::keyCode         key,
    input  piecePkg::pieceKind       pieceType,
    output logic                     ready,
    output boardPkg::gameScore       score,
    output logic [`VISIBLE_CELLS-1:0] objects,
    output logic                     gameOver
);

    boardPkg::rowCells      boardCells [`BOARD_ROWS];
    boardPkg::rowCells      pieceMask [`BOARD_ROWS];
    boardPkg::rowCells      aboveCells [`BOARD_ROWS];
    logic [`BOARD_ROWS-1:0] rowFull;
    logic [`BOARD_ROWS-1:0] shiftEn;
    logic                   lock;
    logic                   clearDone;

    pieceControl u_ctrl (
        .clk        (clk),
        .rst        (rst),
        .key        (key),
        .pieceType  (pieceType),
        .boardCells (boardCells),
        .clearDone  (clearDone),
        .pieceMask  (pieceMask),
        .lock       (lock),
        .ready      (ready),
        .gameOver   (gameOver)
    );

    // ####################
    // Board rows
    // ####################

    for (genvar r = 0; r < `BOARD_ROWS; r++) begin : rows
        // Top row fills with empty cells on a shift
        if (r == 0) begin : gTop
            assign aboveCells[r] = '0;
        end else begin : gBelow
            assign aboveCells[r] = boardCells[r-1];
        end

        boardRow u_row (
            .clk        (clk),
            .rst        (rst),
            .lock       (lock),
            .pieceMask  (pieceMask[r]),
            .shiftEn    (shiftEn[r]),
            .aboveCells (aboveCells[r]),
            .cells      (boardCells[r]),
            .full       (rowFull[r])
        );
    end

    lineClearScore u_clear (
        .clk       (clk),
        .rst       (rst),
        .lock      (lock),
        .rowFull   (rowFull),
        .shiftEn   (shiftEn),
        .clearDone (clearDone),
        .score     (score)
    );

    // Visible row 0 (board row 4) in the lowest ten bits
    for (genvar v = 0; v < `BOARD_ROWS - `HIDDEN_ROWS; v++) begin : view
        assign objects[v*`BOARD_COLS +: `BOARD_COLS] =
            boardCells[v + `HIDDEN_ROWS] | pieceMask[v + `HIDDEN_ROWS];
    end

endmodule

// File: hw/pieceControl.sv
`timescale 1ns/1ps
`include "tetris_consts.svh"

module pieceControl (
    input  logic               clk,
    input  logic               rst,
    input  piecePkg::keyCode   key,
    input  piecePkg::pieceKind pieceType,
    input  boardPkg::rowCells  boardCells [`BOARD_ROWS],
    input  logic               clearDone,
    output boardPkg::rowCells  pieceMask [`BOARD_ROWS],
    output logic               lock,
    output logic               ready,
    output logic               gameOver
);

    piecePkg::ctrlState state;
    piecePkg::pieceKind kind;
    boardPkg::rowIndex  centerRow;
    boardPkg::colIndex  centerCol;

    piecePkg::keyCode      cmd;
    logic                  accept;
    logic                  moveDown;
    logic signed [1:0]     moveCol;
    piecePkg::pieceKind    testKind;
    boardPkg::rowIndex     baseRow;
    boardPkg::colIndex     baseCol;
    piecePkg::pieceOffsets offs;

    logic signed [5:0] curRow [4];
    logic signed [4:0] curCol [4];
    logic signed [5:0] candRow [4];
    logic signed [4:0] candCol [4];
    logic              blocked;
    logic              inHidden;

    assign ready    = (state == piecePkg::sPlay);
    assign lock     = (state == piecePkg::sLock);
    assign gameOver = (state == piecePkg::sOver);

    // Rotate and unknown codes count as idle
    always_comb begin
        case (key)
            piecePkg::keyDrop, piecePkg::keyLeft, piecePkg::keyRight: cmd = key;
            default: cmd = piecePkg::keyIdle;
        endcase
    end

    assign accept   = ready && (cmd != piecePkg::keyIdle);
    assign moveDown = ready && (cmd == piecePkg::keyDrop);
    assign moveCol  = !ready ? 2'sd0 :
                      (cmd == piecePkg::keyLeft) ? -2'sd1 :
                      (cmd == piecePkg::keyRight) ? 2'sd1 : 2'sd0;

    // In sSpawn the new piece is tested at the spawn point
    assign testKind = (state == piecePkg::sSpawn) ? pieceType : kind;
    assign baseRow  = (state == piecePkg::sSpawn) ? boardPkg::rowIndex'(`SPAWN_ROW) : centerRow;
    assign baseCol  = (state == piecePkg::sSpawn) ? boardPkg::colIndex'(`SPAWN_COL) : centerCol;

    // ####################
    // Cells and collision
    // ####################

    always_comb begin
        offs = piecePkg::pieceCells(testKind);
        blocked = 1'b0;
        inHidden = 1'b0;
        for (int i = 0; i < 4; i++) begin
            curRow[i] = $signed({1'b0, baseRow}) + offs[i][0];
            curCol[i] = $signed({1'b0, baseCol}) + offs[i][1];
            candRow[i] = curRow[i] + $signed({1'b0, moveDown});
            candCol[i] = curCol[i] + moveCol;
            if (curRow[i] < `HIDDEN_ROWS) begin
                inHidden = 1'b1;
            end
            // Walls and floor first, then settled cells
            if (candCol[i] < 0 || candCol[i] >= `BOARD_COLS ||
                candRow[i] < 0 || candRow[i] >= `BOARD_ROWS) begin
                blocked = 1'b1;
            end else if (boardCells[candRow[i][4:0]][candCol[i][3:0]]) begin
                blocked = 1'b1;
            end
        end
    end

    // Piece is shown only while it moves and in its lock cycle
    always_comb begin
        for (int r = 0; r < `BOARD_ROWS; r++) begin
            pieceMask[r] = '0;
        end
        if (state == piecePkg::sPlay || state == piecePkg::sLock) begin
            for (int i = 0; i < 4; i++) begin
                pieceMask[curRow[i][4:0]][curCol[i][3:0]] = 1'b1;
            end
        end
    end

    // ####################
    // Controller FSM
    // ####################

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= piecePkg::sSpawn;
            kind <= piecePkg::kindI;
            centerRow <= boardPkg::rowIndex'(`SPAWN_ROW);
            centerCol <= boardPkg::colIndex'(`SPAWN_COL);
        end else begin
            case (state)
                piecePkg::sSpawn: begin
                    kind <= pieceType;
                    centerRow <= boardPkg::rowIndex'(`SPAWN_ROW);
                    centerCol <= boardPkg::colIndex'(`SPAWN_COL);
                    state <= blocked ? piecePkg::sOver : piecePkg::sPlay;
                end
                piecePkg::sPlay: begin
                    if (accept) begin
                        if (!blocked) begin
                            centerRow <= centerRow + boardPkg::rowIndex'(moveDown);
                            centerCol <= centerCol + boardPkg::colIndex'(moveCol);
                        end else if (cmd == piecePkg::keyDrop) begin
                            state <= piecePkg::sLock;
                        end
                    end
                end
                piecePkg::sLock: begin
                    // Piece stuck in the spawn area ends the game
                    state <= inHidden ? piecePkg::sOver : piecePkg::sWaitClear;
                end
                piecePkg::sWaitClear: begin
                    if (clearDone) begin
                        state <= piecePkg::sSpawn;
                    end
                end
                default: begin
                    state <= piecePkg::sOver;
                end
            endcase
        end
    end

endmodule

// File: hw/lineClearScore.sv
`timescale 1ns/1ps
`include "tetris_consts.svh"

module lineClearScore (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   lock,
    input  logic [`BOARD_ROWS-1:0] rowFull,
    output logic [`BOARD_ROWS-1:0] shiftEn,
    output logic                   clearDone,
    output boardPkg::gameScore     score
);

    piecePkg::clearState state;

    logic              found;
    boardPkg::rowIndex clearRow;

    // Lowest full visible row, i.e. the highest row number
    always_comb begin
        found = 1'b0;
        clearRow = '0;
        for (int r = `HIDDEN_ROWS; r < `BOARD_ROWS; r++) begin
            if (rowFull[r]) begin
                found = 1'b1;
                clearRow = boardPkg::rowIndex'(r);
            end
        end
    end

    // Chosen row and everything above it move down by one
    always_comb begin
        for (int r = 0; r < `BOARD_ROWS; r++) begin
            shiftEn[r] = (state == piecePkg::cScan) && found &&
                         (boardPkg::rowIndex'(r) <= clearRow);
        end
    end

    assign clearDone = (state == piecePkg::cScan) && !found;

    // ####################
    // Scan FSM and score
    // ####################

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= piecePkg::cIdle;
            score <= '0;
        end else begin
            case (state)
                piecePkg::cIdle: begin
                    if (lock) begin
                        state <= piecePkg::cScan;
                        score <= score + boardPkg::gameScore'(`LOCK_POINTS);
                    end
                end
                piecePkg::cScan: begin
                    // One row per cycle until nothing is full
                    if (found) begin
                        score <= score + boardPkg::gameScore'(`LINE_POINTS);
                    end else begin
                        state <= piecePkg::cIdle;
                    end
                end
                default: begin
                    state <= piecePkg::cIdle;
                end
            endcase
        end
    end

endmodule

// File: hw/boardRow.sv
`timescale 1ns/1ps

module boardRow (
    input  logic              clk,
    input  logic              rst,
    input  logic              lock,
    input  boardPkg::rowCells pieceMask,
    input  logic              shiftEn,
    input  boardPkg::rowCells aboveCells,
    output boardPkg::rowCells cells,
    output logic              full
);

    // A clear and a lock never share a cycle, the shift wins anyway
    always_ff @(posedge clk) begin
        if (rst) begin
            cells <= '0;
        end else if (shiftEn) begin
            cells <= aboveCells;
        end else if (lock) begin
            cells <= cells | pieceMask;
        end
    end

    assign full = &cells;

endmodule

// File: hw/piecePkg.sv
package piecePkg;

    typedef logic [2:0] pieceKind;
    typedef logic [2:0] keyCode;

    localparam pieceKind kindI = 3'd0;
    localparam pieceKind kindO = 3'd1;
    localparam pieceKind kindT = 3'd2;
    localparam pieceKind kindL = 3'd3;
    localparam pieceKind kindS = 3'd4;

    localparam keyCode keyIdle = 3'b000;
    localparam keyCode keyDrop = 3'b100;
    localparam keyCode keyLeft = 3'b101;
    localparam keyCode keyRight = 3'b110;

    typedef enum logic [2:0] {
        sSpawn,
        sPlay,
        sLock,
        sWaitClear,
        sOver
    } ctrlState;

    typedef enum logic {
        cIdle,
        cScan
    } clearState;

    typedef logic signed [2:0] cellOffset;

    // Per cell: [0] row offset, [1] column offset
    typedef cellOffset [0:3][0:1] pieceOffsets;

    // Offsets from the piece center, first orientation only
    function automatic pieceOffsets pieceCells(input pieceKind kind);
        pieceOffsets offs;
        case (kind)
            kindO: offs = '{'{-3'sd1, 3'sd0}, '{-3'sd1, 3'sd1}, '{3'sd0, 3'sd0}, '{3'sd0, 3'sd1}};
            kindT: offs = '{'{3'sd0, -3'sd1}, '{3'sd0, 3'sd0}, '{3'sd0, 3'sd1}, '{-3'sd1, 3'sd0}};
            kindL: offs = '{'{3'sd0, -3'sd1}, '{3'sd0, 3'sd0}, '{3'sd0, 3'sd1}, '{-3'sd1, 3'sd1}};
            kindS: offs = '{'{3'sd0, -3'sd1}, '{3'sd0, 3'sd0}, '{-3'sd1, 3'sd0}, '{-3'sd1, 3'sd1}};
            // I, and the unused codes 5 to 7
            default: offs = '{'{3'sd0, -3'sd2}, '{3'sd0, -3'sd1}, '{3'sd0, 3'sd0}, '{3'sd0, 3'sd1}};
        endcase
        return offs;
    endfunction

endpackage

// File: hw/boardPkg.sv
`include "tetris_consts.svh"

package boardPkg;

    // One row of settled cells, bit n is column n
    typedef logic [`BOARD_COLS-1:0] rowCells;

    // Row number 0 to 23, row 0 at the top
    typedef logic [4:0] rowIndex;

    // Column number 0 to 9
    typedef logic [3:0] colIndex;

    // Wraps at 128
    typedef logic [6:0] gameScore;

endpackage

// File: hw/tetris_consts.svh
`ifndef TETRIS_CONSTS_SVH
`define TETRIS_CONSTS_SVH

// Board geometry, rows 0 to 3 are the hidden spawn area
`define BOARD_COLS 10
`define BOARD_ROWS 24
`define HIDDEN_ROWS 4
`define VISIBLE_CELLS 200

// Piece center on spawn
`define SPAWN_COL 5
`define SPAWN_ROW 2

// Points
`define LOCK_POINTS 1
`define LINE_POINTS 10

`endif
